// File: design/drone_macros.svh
// Motor output stage constants
`ifndef DRONE_MACROS_SVH
`define DRONE_MACROS_SVH

// Axis rates are Q12.4 two's complement, 12 integer bits over 4 fraction bits
`define RATE_BIT_WIDTH 16

// Motor rates double as the PWM duty and set the PWM counter width
`define MOTOR_RATE_BIT_WIDTH 8

// Four rotors on an X frame
`define NUM_MOTORS 4

// Mixer sums carry two guard bits above a rate so they clamp instead of wrapping
`define MOTOR_SUM_BIT_WIDTH 18

// The clamped motor value fits in 10 bits, and bits 9 down to 2 form the motor rate
`define MOTOR_VAL_BIT_WIDTH 10

// Arithmetic right shifts applied to each axis before mixing, so each axis is halved
`define MOTOR_RATE_YAW_SCALER 1
`define MOTOR_RATE_ROLL_SCALER 1
`define MOTOR_RATE_PITCH_SCALER 1

// Per-motor trim in Q12.4, where 16 is 1.0
`define MOTOR_1_RATE_BIAS 16
`define MOTOR_2_RATE_BIAS 0
`define MOTOR_3_RATE_BIAS 16
`define MOTOR_4_RATE_BIAS 0

// 64 is 4.0 in Q12.4 and is both the arming threshold and the idle floor
`define MOTOR_VAL_MIN 64
`define MOTOR_VAL_MAX 1023

`endif

// File: design/drone_pkg.sv
// Motor output stage types
`include "drone_macros.svh"

package drone_pkg;

  // One axis command in Q12.4
  typedef logic signed [`RATE_BIT_WIDTH-1:0] rate_t;

  // One motor speed, which is also the PWM duty in counts out of 256
  typedef logic [`MOTOR_RATE_BIT_WIDTH-1:0] motor_rate_t;

  // The four commands from the rate controllers
  typedef struct packed {
    rate_t throttle;
    rate_t yaw;
    rate_t roll;
    rate_t pitch;
  } axis_rates_t;

  // Motor 1 sits in the low byte so that byte index matches the pwm bit index
  typedef struct packed {
    motor_rate_t m4;
    motor_rate_t m3;
    motor_rate_t m2;
    motor_rate_t m1;
  } motor_rates_t;

  // Mixer pipeline steps, walked in this order once per round
  typedef enum logic [2:0] {
    SCALE_RATES,
    CONVERT_RATES,
    MOTOR_RATE_CALC,
    BOUNDARY_CHECK,
    SEND_OUTPUT
  } mixer_state_e;

endpackage

// File: design/motor_mixer.sv
// X-frame motor mixer
`timescale 1ns/1ps
`include "drone_macros.svh"

module motor_mixer (
  input  logic                    sys_clk,
  input  logic                    resetn,
  input  drone_pkg::axis_rates_t  axis_rates,
  output drone_pkg::motor_rates_t motor_rates
);

  import drone_pkg::*;

  // Wide enough that bias plus throttle plus three halved axes never overflows
  typedef logic signed [`MOTOR_SUM_BIT_WIDTH-1:0] motor_sum_t;

  // Signed share of each axis that one motor receives
  typedef struct packed {
    rate_t yaw;
    rate_t roll;
    rate_t pitch;
  } mix_terms_t;

  // X-frame sign table with one bit per motor, bit 0 for motor 1
  // A set bit means that motor takes the negated axis
  // Motor 1 is -yaw +roll +pitch, motor 2 is +yaw -roll +pitch
  // Motor 3 is -yaw -roll -pitch, motor 4 is +yaw +roll -pitch
  localparam logic [`NUM_MOTORS-1:0] YAW_NEG   = 4'b0101;
  localparam logic [`NUM_MOTORS-1:0] ROLL_NEG  = 4'b0110;
  localparam logic [`NUM_MOTORS-1:0] PITCH_NEG = 4'b1100;

  localparam motor_sum_t MOTOR_BIAS [`NUM_MOTORS] = '{
    motor_sum_t'(`MOTOR_1_RATE_BIAS),
    motor_sum_t'(`MOTOR_2_RATE_BIAS),
    motor_sum_t'(`MOTOR_3_RATE_BIAS),
    motor_sum_t'(`MOTOR_4_RATE_BIAS)
  };

  mixer_state_e state;

  // Throttle passes unscaled, the three axes are halved on capture
  axis_rates_t scaled;

  mix_terms_t terms [`NUM_MOTORS];
  motor_sum_t sums [`NUM_MOTORS];
  logic [`MOTOR_VAL_BIT_WIDTH-1:0] clamped [`NUM_MOTORS];

  // Reduced rates in pwm bit order, ready to load into the output struct
  motor_rate_t [`NUM_MOTORS-1:0] next_rates;

  // The whole word is negated, fraction bits included
  // Halving keeps the value away from the most negative code, so this never overflows
  function automatic rate_t signed_term(rate_t value, logic negate);
    return negate ? -value : value;
  endfunction

  // Sign extension of a Q12.4 rate to sum width
  function automatic motor_sum_t widen(rate_t value);
    return motor_sum_t'(value);
  endfunction

  // Datapath that takes one step per state
  always_ff @(posedge sys_clk) begin
    case (state)
      SCALE_RATES: begin
        scaled.throttle <= axis_rates.throttle;
        scaled.yaw      <= axis_rates.yaw >>> `MOTOR_RATE_YAW_SCALER;
        scaled.roll     <= axis_rates.roll >>> `MOTOR_RATE_ROLL_SCALER;
        scaled.pitch    <= axis_rates.pitch >>> `MOTOR_RATE_PITCH_SCALER;
      end
      CONVERT_RATES: begin
        // Apply the sign table so the next step only has to add
        for (int m = 0; m < `NUM_MOTORS; m++) begin
          terms[m].yaw   <= signed_term(scaled.yaw, YAW_NEG[m]);
          terms[m].roll  <= signed_term(scaled.roll, ROLL_NEG[m]);
          terms[m].pitch <= signed_term(scaled.pitch, PITCH_NEG[m]);
        end
      end
      MOTOR_RATE_CALC: begin
        for (int m = 0; m < `NUM_MOTORS; m++) begin
          sums[m] <= MOTOR_BIAS[m] + widen(scaled.throttle) + widen(terms[m].yaw) +
                     widen(terms[m].roll) + widen(terms[m].pitch);
        end
      end
      BOUNDARY_CHECK: begin
        for (int m = 0; m < `NUM_MOTORS; m++) begin
          if (scaled.throttle <= rate_t'(`MOTOR_VAL_MIN)) begin
            // Disarmed, so no motor spins regardless of attitude demand
            clamped[m] <= '0;
          end else if (sums[m] < motor_sum_t'(`MOTOR_VAL_MIN)) begin
            clamped[m] <= `MOTOR_VAL_BIT_WIDTH'(`MOTOR_VAL_MIN);
          end else if (sums[m] > motor_sum_t'(`MOTOR_VAL_MAX)) begin
            clamped[m] <= `MOTOR_VAL_BIT_WIDTH'(`MOTOR_VAL_MAX);
          end else begin
            // In range, so the low bits already hold the whole value
            clamped[m] <= sums[m][`MOTOR_VAL_BIT_WIDTH-1:0];
          end
        end
      end
      default: begin
        // SEND_OUTPUT and illegal codes leave the datapath untouched
      end
    endcase
  end

  // Bits 9 down to 2 of the clamped value, so MOTOR_VAL_MIN maps to 16 and MAX to 255
  always_comb begin
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      next_rates[m] = clamped[m][`MOTOR_VAL_BIT_WIDTH-1 -: `MOTOR_RATE_BIT_WIDTH];
    end
  end

  // Sequencer and output register
  // The round is fixed at five clocks with no stalls, so outputs refresh every 5 cycles
  always_ff @(posedge sys_clk or negedge resetn) begin
    if (!resetn) begin
      state       <= SCALE_RATES;
      motor_rates <= '0;
    end else begin
      case (state)
        SCALE_RATES: begin
          state <= CONVERT_RATES;
        end
        CONVERT_RATES: begin
          state <= MOTOR_RATE_CALC;
        end
        MOTOR_RATE_CALC: begin
          state <= BOUNDARY_CHECK;
        end
        BOUNDARY_CHECK: begin
          state <= SEND_OUTPUT;
        end
        SEND_OUTPUT: begin
          motor_rates <= motor_rates_t'(next_rates);
          state       <= SCALE_RATES;
        end
        default: begin
          // An upset state code stops the motors and restarts the round
          motor_rates <= '0;
          state       <= SCALE_RATES;
        end
      endcase
    end
  end

endmodule

// File: design/pwm_generator.sv
// Single channel motor PWM
`timescale 1ns/1ps
`include "drone_macros.svh"

module pwm_generator (
  input  logic                   sys_clk,
  input  logic                   resetn,
  input  drone_pkg::motor_rate_t duty,
  output logic                   pwm
);

  import drone_pkg::*;

  // Free-running period counter, 256 clocks per period
  logic [`MOTOR_RATE_BIT_WIDTH-1:0] count;

  // Duty held for the whole period
  motor_rate_t duty_q;

  // Duty in force for the current count
  // At count zero the fresh input is used, since the latch only loads on that edge
  motor_rate_t duty_now;

  assign duty_now = (count == '0) ? duty : duty_q;

  always_ff @(posedge sys_clk or negedge resetn) begin
    if (!resetn) begin
      count <= '0;
      pwm   <= 1'b0;
    end else begin
      count <= count + 1'b1;
      // High for counts 0 to N-1, which gives exactly N high cycles per period
      pwm   <= (count < duty_now);
    end
  end

  // Sample duty only at period start so a mid-period change cannot chop a pulse
  // The first edge after reset sees count zero, which loads the latch
  always_ff @(posedge sys_clk) begin
    if (count == '0) begin
      duty_q <= duty;
    end
  end

endmodule

// File: design/motor_output_stage.sv
// Motor mixer and PWM outputs
`timescale 1ns/1ps
`include "drone_macros.svh"

module motor_output_stage (
  input  logic                    sys_clk,
  input  logic                    resetn,
  input  drone_pkg::axis_rates_t  axis_rates,
  output drone_pkg::motor_rates_t motor_rates,
  output logic [`NUM_MOTORS-1:0]  pwm
);

  import drone_pkg::*;

  // The motor struct viewed as a byte array, index 0 is motor 1
  motor_rate_t [`NUM_MOTORS-1:0] duty;

  assign duty = motor_rates;

  // Commands are levels, sampled once per five-clock mixer round
  motor_mixer i_motor_mixer (
    .sys_clk     (sys_clk),
    .resetn      (resetn),
    .axis_rates  (axis_rates),
    .motor_rates (motor_rates)
  );

  // One PWM channel per rotor
  // All counters leave reset together, so the four periods stay aligned
  for (genvar m = 0; m < `NUM_MOTORS; m++) begin : g_pwm
    pwm_generator i_pwm_generator (
      .sys_clk (sys_clk),
      .resetn  (resetn),
      .duty    (duty[m]),
      .pwm     (pwm[m])
    );
  end

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic sys_clk,
  output logic resetn
);

  // 100 ns clock period
  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 10;

  // Reset is released just after a rising edge, the same way stimulus is driven
  localparam int DRIVE_DELAY = 1;

  initial begin
    sys_clk = 1'b0;
    forever #HALF_PERIOD sys_clk = ~sys_clk;
  end

  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #DRIVE_DELAY;
    resetn = 1'b1;
  end

endmodule

// File: sim/tb_motor_output_stage.sv
// Motor output stage testbench
`timescale 1ns/1ps
`include "drone_macros.svh"

module tb_motor_output_stage;

  import drone_pkg::*;

  // A held command shows up on motor_rates within 10 cycles
  localparam int HOLD_CYCLES = 12;
  localparam int PWM_PERIOD = 256;
  // Time from an input change until a whole period with the new duty has gone by
  localparam int PWM_SETTLE_CYCLES = 2 * PWM_PERIOD;
  localparam int RESET_CYCLES = 10;
  localparam int MARGIN_CYCLES = 100;
  localparam int NUM_RANDOM = 20;
  localparam logic [31:0] LFSR_SEED = 32'hfd84fb24;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  typedef struct packed {
    axis_rates_t  stim;
    motor_rates_t expected;
    logic         check_pwm;
  } test_row_t;

  logic                   sys_clk;
  logic                   resetn;
  axis_rates_t            axis_rates;
  motor_rates_t           motor_rates;
  logic [`NUM_MOTORS-1:0] pwm;

  test_row_t table_rows [$];
  string     row_names [$];
  logic [31:0] lfsr_state;
  int pwm_high [`NUM_MOTORS];
  int cycle_count = 0;
  int cycle_limit;
  int check_errors;
  int tests_run;
  int tests_failed;

  tb_clock_gen i_tb_clock_gen (
    .sys_clk (sys_clk),
    .resetn  (resetn)
  );

  motor_output_stage i_motor_output_stage (
    .sys_clk     (sys_clk),
    .resetn      (resetn),
    .axis_rates  (axis_rates),
    .motor_rates (motor_rates),
    .pwm         (pwm)
  );

  // Galois form where the bit shifted out is the random bit
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  task automatic take_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Disarm, clamp, then keep bits 9 down to 2
  function automatic motor_rate_t expected_rate(int throttle, int sum);
    int val;
    if (throttle <= `MOTOR_VAL_MIN) begin
      return '0;
    end
    val = sum;
    if (val < `MOTOR_VAL_MIN) val = `MOTOR_VAL_MIN;
    else if (val > `MOTOR_VAL_MAX) val = `MOTOR_VAL_MAX;
    return motor_rate_t'(val >> 2);
  endfunction

  // X-frame equations on halved axes, worked in plain integers
  function automatic motor_rates_t mix_model(axis_rates_t cmd);
    int t;
    int y;
    int r;
    int p;
    motor_rates_t res;
    t = int'($signed(cmd.throttle));
    y = int'($signed(cmd.yaw)) >>> `MOTOR_RATE_YAW_SCALER;
    r = int'($signed(cmd.roll)) >>> `MOTOR_RATE_ROLL_SCALER;
    p = int'($signed(cmd.pitch)) >>> `MOTOR_RATE_PITCH_SCALER;
    res.m1 = expected_rate(t, `MOTOR_1_RATE_BIAS + t - y + r + p);
    res.m2 = expected_rate(t, `MOTOR_2_RATE_BIAS + t + y - r + p);
    res.m3 = expected_rate(t, `MOTOR_3_RATE_BIAS + t - y - r - p);
    res.m4 = expected_rate(t, `MOTOR_4_RATE_BIAS + t + y + r - p);
    return res;
  endfunction

  task automatic add_row(input string name, input int throttle, input int yaw,
                         input int roll, input int pitch, input logic check_pwm);
    test_row_t row;
    row.stim.throttle = rate_t'(throttle);
    row.stim.yaw      = rate_t'(yaw);
    row.stim.roll     = rate_t'(roll);
    row.stim.pitch    = rate_t'(pitch);
    row.expected      = mix_model(row.stim);
    row.check_pwm     = check_pwm;
    table_rows.push_back(row);
    row_names.push_back(name);
  endtask

  task automatic build_table();
    logic [31:0] bits;
    int throttle;
    int yaw;
    int roll;
    int pitch;
    // Disarmed rows, including the threshold itself
    add_row("disarmed zero throttle", 0, 0, 0, 0, 1'b1);
    add_row("disarmed at threshold", 64, 400, -300, 200, 1'b0);
    add_row("disarmed negative throttle", -100, 1000, 1000, 1000, 1'b0);
    add_row("armed above threshold", 65, 0, 0, 0, 1'b0);
    // Negative and odd values in single axes and mixes test the shift and sign
    add_row("throttle only", 400, 0, 0, 0, 1'b1);
    add_row("yaw positive", 400, 64, 0, 0, 1'b0);
    add_row("yaw negative odd", 400, -3, 0, 0, 1'b0);
    add_row("roll negative", 400, 0, -80, 0, 1'b0);
    add_row("pitch positive", 400, 0, 0, 48, 1'b0);
    add_row("combined axes", 600, -40, 24, -56, 1'b1);
    add_row("combined fractional", 1000, 173, -91, 255, 1'b0);
    // Saturation at both clamp limits
    add_row("saturate high", 1500, 0, 0, 0, 1'b0);
    add_row("saturate mixed", 300, 2000, 2000, 2000, 1'b1);
    add_row("saturate inverse", 300, -2000, -2000, -2000, 1'b0);
    add_row("full scale extremes", 32767, -32768, -32768, -32768, 1'b0);
    // Throttle is mostly armed and axes spread both ways so some rows clamp
    for (int n = 0; n < NUM_RANDOM; n++) begin
      take_bits(11, bits);
      throttle = int'(bits);
      take_bits(10, bits);
      yaw = int'(bits) - 512;
      take_bits(10, bits);
      roll = int'(bits) - 512;
      take_bits(10, bits);
      pitch = int'(bits) - 512;
      add_row($sformatf("random %0d", n), throttle, yaw, roll, pitch, n < 2);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      check_errors++;
    end
  endtask

  // Counts high cycles on every channel over one period
  task automatic measure_pwm_duty();
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      pwm_high[m] = 0;
    end
    repeat (PWM_PERIOD) begin
      @(posedge sys_clk);
      #1;
      for (int m = 0; m < `NUM_MOTORS; m++) begin
        if (pwm[m]) pwm_high[m]++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (check_errors == errors_before) begin
      $display("Test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: fail, %0d errors", tests_run, name, check_errors - errors_before);
    end
  endtask

  task automatic check_reset_state();
    int errors_before;
    errors_before = check_errors;
    @(posedge sys_clk);
    #1;
    check_value("motor_rates in reset", 32'(motor_rates), 32'h0);
    check_value("pwm in reset", 32'(pwm), 32'h0);
    wait (resetn === 1'b1);
    @(posedge sys_clk);
    #1;
    check_value("motor_rates after reset", 32'(motor_rates), 32'h0);
    // Inputs are zero, so the outputs stay low for the whole first period
    measure_pwm_duty();
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      check_value($sformatf("pwm[%0d] high count", m), 32'(pwm_high[m]), 32'h0);
    end
    report_test("reset state", errors_before);
  endtask

  task automatic apply_row(input string name, input test_row_t row);
    int errors_before;
    motor_rate_t [`NUM_MOTORS-1:0] got;
    motor_rate_t [`NUM_MOTORS-1:0] want;
    errors_before = check_errors;
    @(posedge sys_clk);
    #1;
    axis_rates = row.stim;
    repeat (HOLD_CYCLES) @(posedge sys_clk);
    #1;
    got  = motor_rates;
    want = row.expected;
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      check_value($sformatf("motor_rates.m%0d", m + 1), 32'(got[m]), 32'(want[m]));
    end
    if (row.check_pwm) begin
      // Let the new duty be latched and run one whole period first
      repeat (PWM_SETTLE_CYCLES - HOLD_CYCLES) @(posedge sys_clk);
      measure_pwm_duty();
      for (int m = 0; m < `NUM_MOTORS; m++) begin
        check_value($sformatf("pwm[%0d] high count", m), 32'(pwm_high[m]), 32'(want[m]));
      end
    end
    report_test(name, errors_before);
  endtask

  // Ends a stuck run once the summed test lengths are exceeded
  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int pwm_rows;
    axis_rates   = '0;
    check_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = LFSR_SEED;
    build_table();
    pwm_rows = 0;
    for (int i = 0; i < table_rows.size(); i++) begin
      if (table_rows[i].check_pwm) pwm_rows++;
    end
    // A row with a duty check adds the settle time and one measured period
    cycle_limit = RESET_CYCLES + PWM_PERIOD + table_rows.size() * (HOLD_CYCLES + 1) +
                  pwm_rows * (PWM_SETTLE_CYCLES + PWM_PERIOD) + MARGIN_CYCLES;
    check_reset_state();
    for (int i = 0; i < table_rows.size(); i++) begin
      apply_row(row_names[i], table_rows[i]);
    end
    $display("Tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, check_errors);
    if (check_errors == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+design
design/drone_pkg.sv
design/motor_mixer.sv
design/pwm_generator.sv
design/motor_output_stage.sv
sim/tb_clock_gen.sv
sim/tb_motor_output_stage.sv

// File: Makefile
# Verilator flow for the motor output stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module motor_output_stage

sim:
	verilator --binary --timing -j 0 -f all.f --top-module tb_motor_output_stage -o tb_sim
	@out=$$(./obj_dir/tb_sim); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
